/* bench/int_isq_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module int_isq_checker (
    input wire                                       clock,
    input wire                                       reset_n,
    input wire                                       enq_valid,
    input wire                                       can_alloc,
    input wire                                       issue_valid,
    input wire                                       issue_ready,
    input wire int_isq_pkg::iq_issue_t               issue
);

    // Read back by the testbench when it decides the final result
    int assert_failures = 0;

    // ------------------------------
    // Issue port
    // ------------------------------

    a_no_issue_in_reset: assert property (@(posedge clock) !reset_n |-> !issue_valid)
        else begin
            assert_failures++;
            $error("issue_valid was high while reset_n was low");
        end

    // An offered instruction must wait for the consumer
    a_hold_under_backpressure: assert property (@(posedge clock) disable iff (!reset_n)
        (issue_valid && !issue_ready) |=> (issue_valid && $stable(issue)))
        else begin
            assert_failures++;
            $error("issue changed or dropped while issue_ready was low");
        end

    // ------------------------------
    // Dispatch port
    // ------------------------------

    // The queue is only full after a dispatch took the last entry, or if it was
    // already full and nothing left through the issue port
    a_alloc_when_free: assert property (@(posedge clock) disable iff (!reset_n)
        !can_alloc |-> ($past(enq_valid && can_alloc) ||
                        $past(!can_alloc && !(issue_valid && issue_ready))))
        else begin
            assert_failures++;
            $error("can_alloc was low although an entry had to be free");
        end

endmodule

`default_nettype wire

/* bench/int_isq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module int_isq_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int TABLE_ROWS  = 39;
    localparam int RAND_CYCLES = 200;
    localparam int TIMEOUT_NS  = (TABLE_ROWS + RAND_CYCLES + 20) * CLK_PERIOD;

    // One cycle of stimulus and the values expected in that same cycle
    typedef struct packed {
        logic                                  enq_valid;
        int_isq_pkg::rob_id_t                  robid;
        logic                                  src_reg;
        logic [int_isq_pkg::PREG_W-1:0]        src_preg;
        logic                                  src_ready;
        logic                                  wb0_valid;
        logic                                  wb0_need;
        logic                                  wb1_valid;
        logic [int_isq_pkg::PREG_W-1:0]        wb_prd;
        logic                                  flush_valid;
        int_isq_pkg::rob_id_t                  flush_robid;
        logic                                  issue_ready;
        logic                                  exp_can_alloc;
        logic                                  exp_issue_valid;
        int_isq_pkg::rob_id_t                  exp_robid;
        logic [int_isq_pkg::PMU_CNT_W-1:0]     exp_block;
        logic [int_isq_pkg::PMU_CNT_W-1:0]     exp_more;
    } stim_row_t;

    logic                                  clock;
    logic                                  reset_n;
    logic                                  enq_valid;
    int_isq_pkg::iq_enq_t                  enq;
    logic                                  can_alloc;
    logic                                  wb0_valid;
    logic                                  wb0_need_to_wb;
    logic [int_isq_pkg::PREG_W-1:0]        wb0_prd;
    logic                                  wb1_valid;
    logic [int_isq_pkg::PREG_W-1:0]        wb1_prd;
    int_isq_pkg::iq_flush_t                flush;
    logic                                  issue_valid;
    logic                                  issue_ready;
    int_isq_pkg::iq_issue_t                issue;
    logic [int_isq_pkg::PMU_CNT_W-1:0]     pmu_block_enq_cycles;
    logic [int_isq_pkg::PMU_CNT_W-1:0]     pmu_can_issue_more;

    stim_row_t            stim [TABLE_ROWS];
    int                   row_count;
    int                   error_count;
    logic [31:0]          rng_state;
    int_isq_pkg::rob_id_t order_q [$];
    logic                 held_valid;
    int_isq_pkg::rob_id_t held_rob;

    int_isq int_isq_inst (
        .clock                (clock),
        .reset_n              (reset_n),
        .enq_valid            (enq_valid),
        .enq                  (enq),
        .can_alloc            (can_alloc),
        .wb0_valid            (wb0_valid),
        .wb0_need_to_wb       (wb0_need_to_wb),
        .wb0_prd              (wb0_prd),
        .wb1_valid            (wb1_valid),
        .wb1_prd              (wb1_prd),
        .flush                (flush),
        .issue_valid          (issue_valid),
        .issue_ready          (issue_ready),
        .issue                (issue),
        .pmu_block_enq_cycles (pmu_block_enq_cycles),
        .pmu_can_issue_more   (pmu_can_issue_more)
    );

    bind int_isq int_isq_checker int_isq_checker_inst (
        .clock       (clock),
        .reset_n     (reset_n),
        .enq_valid   (enq_valid),
        .can_alloc   (can_alloc),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic logic [31:0] next_random(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Each instruction carries a pc tied to its robid so the payload mux can be checked
    function automatic logic [int_isq_pkg::PC_W-1:0] pc_for(input int_isq_pkg::rob_id_t rob);
        return {30'h0, rob, 2'b00};
    endfunction

    function automatic void add_row(input int ev, rob, sreg, sprd, srdy, w0v, w0n, w1v, wbp,
                                    flv, flr, ir, ca, iv, erob, blk, more);
        stim_row_t r;
        r.enq_valid       = (ev != 0);
        r.robid           = rob[int_isq_pkg::ROB_IDX_W:0];
        r.src_reg         = (sreg != 0);
        r.src_preg        = sprd[int_isq_pkg::PREG_W-1:0];
        r.src_ready       = (srdy != 0);
        r.wb0_valid       = (w0v != 0);
        r.wb0_need        = (w0n != 0);
        r.wb1_valid       = (w1v != 0);
        r.wb_prd          = wbp[int_isq_pkg::PREG_W-1:0];
        r.flush_valid     = (flv != 0);
        r.flush_robid     = flr[int_isq_pkg::ROB_IDX_W:0];
        r.issue_ready     = (ir != 0);
        r.exp_can_alloc   = (ca != 0);
        r.exp_issue_valid = (iv != 0);
        r.exp_robid       = erob[int_isq_pkg::ROB_IDX_W:0];
        r.exp_block       = blk;
        r.exp_more        = more;
        stim[row_count]   = r;
        row_count++;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("FAILED time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
        end
    endtask

    // ------------------------------
    // Stimulus table
    // ------------------------------

    task automatic build_stim();
        // Reset state, then ready instructions under back-pressure and in a stream
        //     ev rob sr prd rdy w0v w0n w1v wbp fv frob ir ca iv erob blk more
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  0, 1, 0,  0,  0,  0);
        add_row(1,  1, 0,  0,  1,  0,  0,  0,  0, 0,  0,  0, 1, 0,  0,  0,  0);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  0, 1, 1,  1,  0,  0);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  0, 1, 1,  1,  0,  0);
        add_row(1,  2, 0,  0,  1,  0,  0,  0,  0, 0,  0,  1, 1, 1,  1,  0,  0);
        add_row(1,  3, 0,  0,  1,  0,  0,  0,  0, 0,  0,  1, 1, 1,  2,  0,  0);
        add_row(1,  4, 0,  0,  1,  0,  0,  0,  0, 0,  0,  1, 1, 1,  3,  0,  0);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  1, 1, 1,  4,  0,  0);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  0, 1, 0,  0,  0,  0);
        // Three waiters on preg 10 that a wb0 strobe without need_to_wb must not wake
        add_row(1,  5, 1, 10,  0,  0,  0,  0,  0, 0,  0,  1, 1, 0,  0,  0,  0);
        add_row(1,  6, 1, 10,  0,  0,  0,  0,  0, 0,  0,  1, 1, 0,  0,  0,  0);
        add_row(1,  7, 1, 10,  0,  1,  0,  0, 10, 0,  0,  1, 1, 0,  0,  0,  0);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  1, 1, 0,  0,  0,  0);
        add_row(0,  0, 0,  0,  0,  0,  0,  1, 10, 0,  0,  1, 1, 0,  0,  0,  0);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  1, 1, 1,  5,  0,  0);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  1, 1, 1,  6,  0,  1);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  1, 1, 1,  7,  0,  2);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  1, 1, 0,  0,  0,  2);
        // Fill all eight entries with waiters on preg 20, then push against a full queue
        add_row(1,  8, 1, 20,  0,  0,  0,  0,  0, 0,  0,  1, 1, 0,  0,  0,  2);
        add_row(1,  9, 1, 20,  0,  0,  0,  0,  0, 0,  0,  1, 1, 0,  0,  0,  2);
        add_row(1, 10, 1, 20,  0,  0,  0,  0,  0, 0,  0,  1, 1, 0,  0,  0,  2);
        add_row(1, 11, 1, 20,  0,  0,  0,  0,  0, 0,  0,  1, 1, 0,  0,  0,  2);
        add_row(1, 12, 1, 20,  0,  0,  0,  0,  0, 0,  0,  1, 1, 0,  0,  0,  2);
        add_row(1, 13, 1, 20,  0,  0,  0,  0,  0, 0,  0,  1, 1, 0,  0,  0,  2);
        add_row(1, 14, 1, 20,  0,  0,  0,  0,  0, 0,  0,  1, 1, 0,  0,  0,  2);
        add_row(1, 15, 1, 20,  0,  0,  0,  0,  0, 0,  0,  1, 1, 0,  0,  0,  2);
        add_row(1, 16, 1, 20,  0,  0,  0,  0,  0, 0,  0,  1, 0, 0,  0,  0,  2);
        add_row(1, 16, 1, 20,  0,  0,  0,  0,  0, 0,  0,  1, 0, 0,  0,  1,  2);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  1, 0, 0,  0,  2,  2);
        // Flush past robid 11, then past robid 9 while a new instruction dispatches
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 1, 11,  1, 0, 0,  0,  2,  2);
        add_row(1, 12, 1, 20,  0,  0,  0,  0,  0, 1,  9,  1, 1, 0,  0,  2,  2);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  1, 1, 0,  0,  2,  2);
        // Robid 13 dispatches alongside the wakeup and so keeps waiting
        add_row(1, 13, 1, 20,  0,  0,  0,  1, 20, 0,  0,  1, 1, 0,  0,  2,  2);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  1, 1, 1,  8,  2,  2);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  1, 1, 1,  9,  2,  3);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  1, 1, 1, 12,  2,  4);
        add_row(0,  0, 0,  0,  0,  1,  1,  0, 20, 0,  0,  1, 1, 0,  0,  2,  4);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  1, 1, 1, 13,  2,  4);
        add_row(0,  0, 0,  0,  0,  0,  0,  0,  0, 0,  0,  1, 1, 0,  0,  2,  4);
    endtask

    task automatic drive_row(input stim_row_t r);
        enq                    = '0;
        enq_valid              = r.enq_valid;
        enq.payload.robid      = r.robid;
        enq.payload.pc         = pc_for(r.robid);
        enq.payload.need_to_wb = 1'b1;
        enq.src1.is_reg        = r.src_reg;
        enq.src1.preg          = r.src_preg;
        enq.src1_ready         = r.src_ready;
        enq.src2_ready         = 1'b1;
        wb0_valid              = r.wb0_valid;
        wb0_need_to_wb         = r.wb0_need;
        wb0_prd                = r.wb_prd;
        wb1_valid              = r.wb1_valid;
        wb1_prd                = r.wb_prd;
        flush.valid            = r.flush_valid;
        flush.robid            = r.flush_robid;
        issue_ready            = r.issue_ready;
    endtask

    task automatic check_row(input stim_row_t r);
        check_value("can_alloc", r.exp_can_alloc, can_alloc);
        check_value("issue_valid", r.exp_issue_valid, issue_valid);
        if (r.exp_issue_valid) begin
            check_value("issue.payload.robid", r.exp_robid, issue.payload.robid);
            check_value("issue.payload.pc", pc_for(r.exp_robid), issue.payload.pc);
        end
        check_value("pmu_block_enq_cycles", r.exp_block, pmu_block_enq_cycles);
        check_value("pmu_can_issue_more", r.exp_more, pmu_can_issue_more);
    endtask

    // ------------------------------
    // Random order phase
    // ------------------------------

    // Every issued robid must be the oldest one still outstanding
    task automatic observe_issue();
        if (held_valid) begin
            if (!issue_valid) begin
                error_count++;
                $display("Offered instruction vanished while issue_ready was low");
            end else begin
                check_value("issue.payload.robid (held)", held_rob, issue.payload.robid);
            end
        end
        held_valid = 1'b0;
        if (issue_valid && issue_ready) begin
            if (order_q.size() == 0) begin
                error_count++;
                $display("Issue port offered an instruction that was never dispatched");
            end else begin
                check_value("issue.payload.robid", order_q.pop_front(), issue.payload.robid);
            end
        end else if (issue_valid) begin
            held_valid = 1'b1;
            held_rob   = issue.payload.robid;
        end
    endtask

    task automatic run_random_phase();
        int_isq_pkg::rob_id_t next_rob;
        logic                 dispatching;
        next_rob   = 7'd40;
        held_valid = 1'b0;
        for (int c = 0; c < RAND_CYCLES; c++) begin
            @(posedge clock);
            #1;
            rng_state              = next_random(rng_state);
            dispatching            = rng_state[3] && can_alloc;
            enq                    = '0;
            enq.payload.robid      = next_rob;
            enq.payload.pc         = pc_for(next_rob);
            enq.src1_ready         = 1'b1;
            enq.src2_ready         = 1'b1;
            enq_valid              = rng_state[3];
            issue_ready            = rng_state[7];
            wb0_valid              = 1'b0;
            wb1_valid              = 1'b0;
            flush                  = '0;
            @(negedge clock);
            observe_issue();
            if (dispatching) begin
                order_q.push_back(next_rob);
                next_rob = next_rob + 1'b1;
            end
        end
    endtask

    task automatic drain_queue();
        for (int k = 0; (k < int_isq_pkg::ISSUE_QUEUE_DEPTH + 2) && (order_q.size() > 0); k++)
        begin
            @(posedge clock);
            #1;
            enq_valid   = 1'b0;
            issue_ready = 1'b1;
            @(negedge clock);
            observe_issue();
        end
        if (order_q.size() != 0) begin
            error_count++;
            $display("%0d dispatched instructions never issued", order_q.size());
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        clock          = 1'b0;
        reset_n        = 1'b0;
        enq_valid      = 1'b0;
        enq            = '0;
        wb0_valid      = 1'b0;
        wb0_need_to_wb = 1'b0;
        wb0_prd        = '0;
        wb1_valid      = 1'b0;
        wb1_prd        = '0;
        flush          = '0;
        issue_ready    = 1'b0;
        row_count      = 0;
        error_count    = 0;
        held_valid     = 1'b0;
        held_rob       = '0;
        rng_state      = 32'd94410;
        build_stim();

        repeat (2) @(posedge clock);
        #1;
        reset_n = 1'b1;

        for (int i = 0; i < row_count; i++) begin
            @(posedge clock);
            #1;
            drive_row(stim[i]);
            @(negedge clock);
            check_row(stim[i]);
        end

        run_random_phase();
        drain_queue();

        $display("Errors: %0d check, %0d assertion", error_count,
                 int_isq_inst.int_isq_checker_inst.assert_failures);
        if ((error_count == 0) && (int_isq_inst.int_isq_checker_inst.assert_failures == 0)) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/age_select.sv */
`timescale 1ns/1ps
`default_nettype none

module age_select (
    input  wire                                        clock,
    input  wire                                        reset_n,
    input  wire  [int_isq_pkg::ISSUE_QUEUE_DEPTH-1:0]  wren_oh,
    input  wire  [int_isq_pkg::ISSUE_QUEUE_DEPTH-1:0]  ready_vec,
    output logic [int_isq_pkg::ISSUE_QUEUE_DEPTH-1:0]  oldest_oh,
    output logic                                       found
);

    // older[i][j] is set when entry i was written before entry j
    logic [int_isq_pkg::ISSUE_QUEUE_DEPTH-1:0][int_isq_pkg::ISSUE_QUEUE_DEPTH-1:0] older;

    // ------------------------------
    // Matrix update
    // ------------------------------

    // A newly written entry clears its own row and sets its column in every other row,
    // which makes it younger than everything already present
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            older <= '0;
        end else begin
            for (int i = 0; i < int_isq_pkg::ISSUE_QUEUE_DEPTH; i++) begin
                for (int j = 0; j < int_isq_pkg::ISSUE_QUEUE_DEPTH; j++) begin
                    if (wren_oh[i]) begin
                        older[i][j] <= 1'b0;
                    end else if (wren_oh[j]) begin
                        older[i][j] <= 1'b1;
                    end
                end
            end
        end
    end

    // ------------------------------
    // Oldest ready pick
    // ------------------------------

    // Stale bits from freed entries do no harm since those entries are never ready
    always_comb begin
        for (int i = 0; i < int_isq_pkg::ISSUE_QUEUE_DEPTH; i++) begin
            oldest_oh[i] = ready_vec[i];
            for (int j = 0; j < int_isq_pkg::ISSUE_QUEUE_DEPTH; j++) begin
                if ((j != i) && ready_vec[j] && older[j][i]) begin
                    oldest_oh[i] = 1'b0;
                end
            end
        end
    end

    assign found = |ready_vec;

endmodule

`default_nettype wire

/* hdl/int_isq.sv */
`timescale 1ns/1ps
`default_nettype none

module int_isq (
    input  wire                                     clock,
    input  wire                                     reset_n,
    // Dispatch
    input  wire                                     enq_valid,
    input  wire int_isq_pkg::iq_enq_t               enq,
    output logic                                    can_alloc,
    // Writeback wakeup
    input  wire                                     wb0_valid,
    input  wire                                     wb0_need_to_wb,
    input  wire [int_isq_pkg::PREG_W-1:0]           wb0_prd,
    input  wire                                     wb1_valid,
    input  wire [int_isq_pkg::PREG_W-1:0]           wb1_prd,
    // Flush
    input  wire int_isq_pkg::iq_flush_t             flush,
    // Issue to execute
    output logic                                    issue_valid,
    input  wire                                     issue_ready,
    output int_isq_pkg::iq_issue_t                  issue,
    // Performance counters
    output logic [int_isq_pkg::PMU_CNT_W-1:0]       pmu_block_enq_cycles,
    output logic [int_isq_pkg::PMU_CNT_W-1:0]       pmu_can_issue_more
);

    logic [int_isq_pkg::ISSUE_QUEUE_DEPTH-1:0] valid_vec;
    logic [int_isq_pkg::ISSUE_QUEUE_DEPTH-1:0] ready_vec;
    logic [int_isq_pkg::ISSUE_QUEUE_DEPTH-1:0] free_vec;
    logic [int_isq_pkg::ISSUE_QUEUE_DEPTH-1:0] enq_ptr_oh;
    logic [int_isq_pkg::ISSUE_QUEUE_DEPTH-1:0] wren_oh;
    logic [int_isq_pkg::ISSUE_QUEUE_DEPTH-1:0] oldest_oh;
    logic [int_isq_pkg::ISSUE_QUEUE_DEPTH-1:0] issuing_vec;
    logic                                      found;
    logic [int_isq_pkg::IQ_IDX_W-1:0]          issue_idx;

    int_isq_pkg::iq_wb_t [int_isq_pkg::WB_PORTS-1:0] wb_ports;
    int_isq_pkg::iq_issue_t                          entry_out [int_isq_pkg::ISSUE_QUEUE_DEPTH];

    // ------------------------------
    // Dispatch
    // ------------------------------

    assign free_vec = ~valid_vec;

    // Isolate the lowest set bit, which is the lowest-numbered free entry
    assign enq_ptr_oh = free_vec & (~free_vec + 1'b1);

    assign can_alloc = |free_vec;
    assign wren_oh   = (enq_valid && can_alloc) ? enq_ptr_oh : '0;

    // Port 0 only wakes dependents when its result is actually written back
    assign wb_ports[0].valid = wb0_valid && wb0_need_to_wb;
    assign wb_ports[0].prd   = wb0_prd;
    assign wb_ports[1].valid = wb1_valid;
    assign wb_ports[1].prd   = wb1_prd;

    // ------------------------------
    // Entries
    // ------------------------------

    genvar gi;
    generate
        for (gi = 0; gi < int_isq_pkg::ISSUE_QUEUE_DEPTH; gi++) begin : gen_entry
            iq_entry entry_inst (
                .clock       (clock),
                .reset_n     (reset_n),
                .enq_wren    (wren_oh[gi]),
                .enq_data    (enq),
                .wb          (wb_ports),
                .flush       (flush),
                .issuing     (issuing_vec[gi]),
                .valid       (valid_vec[gi]),
                .ready_to_go (ready_vec[gi]),
                .entry       (entry_out[gi])
            );
        end
    endgenerate

    // ------------------------------
    // Issue select
    // ------------------------------

    age_select age_select_inst (
        .clock     (clock),
        .reset_n   (reset_n),
        .wren_oh   (wren_oh),
        .ready_vec (ready_vec),
        .oldest_oh (oldest_oh),
        .found     (found)
    );

    // The age matrix gives at most one bit set, so a plain encoder is enough
    always_comb begin
        issue_idx = '0;
        for (int i = 0; i < int_isq_pkg::ISSUE_QUEUE_DEPTH; i++) begin
            if (oldest_oh[i]) begin
                issue_idx = int_isq_pkg::IQ_IDX_W'(i);
            end
        end
    end

    assign issue_valid = found;
    assign issue       = entry_out[issue_idx];
    assign issuing_vec = (issue_valid && issue_ready) ? oldest_oh : '0;

    // ------------------------------
    // Performance counters
    // ------------------------------

    isq_pmu isq_pmu_inst (
        .clock            (clock),
        .reset_n          (reset_n),
        .enq_valid        (enq_valid),
        .can_alloc        (can_alloc),
        .issue_valid      (issue_valid),
        .ready_vec        (ready_vec),
        .block_enq_cycles (pmu_block_enq_cycles),
        .can_issue_more   (pmu_can_issue_more)
    );

endmodule

`default_nettype wire

/* hdl/int_isq_pkg.sv */
`default_nettype none

package int_isq_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------

    localparam int ISSUE_QUEUE_DEPTH = 8;
    localparam int IQ_IDX_W          = 3;
    localparam int PREG_W            = 6;
    localparam int ROB_IDX_W         = 6;
    localparam int SQ_ID_W           = 5;
    localparam int PC_W              = 39;
    localparam int INSTR_W           = 32;
    localparam int XLEN              = 64;
    localparam int ALU_TYPE_W        = 4;
    localparam int LS_SIZE_W         = 4;
    localparam int PMU_CNT_W         = 32;
    localparam int WB_PORTS          = 2;

    // ------------------------------
    // Types
    // ------------------------------

    // Top bit is the wrap bit used for age comparison across a ROB wrap
    typedef logic [ROB_IDX_W:0] rob_id_t;

    typedef struct packed {
        logic              is_reg;
        logic [PREG_W-1:0] preg;
    } iq_src_t;

    // Carried straight through to execute, the queue never looks inside
    typedef struct packed {
        logic [PC_W-1:0]       pc;
        logic [INSTR_W-1:0]    instr;
        logic [XLEN-1:0]       imm;
        logic [PREG_W-1:0]     prd;
        logic [PREG_W-1:0]     old_prd;
        rob_id_t               robid;
        logic [SQ_ID_W-1:0]    sqid;
        logic [ALU_TYPE_W-1:0] alu_type;
        logic                  is_imm;
        logic                  need_to_wb;
        logic                  is_load;
        logic                  is_store;
        logic [LS_SIZE_W-1:0]  ls_size;
    } iq_payload_t;

    typedef struct packed {
        iq_payload_t payload;
        iq_src_t     src1;
        iq_src_t     src2;
        logic        src1_ready;
        logic        src2_ready;
    } iq_enq_t;

    typedef struct packed {
        iq_payload_t payload;
        iq_src_t     src1;
        iq_src_t     src2;
    } iq_issue_t;

    typedef struct packed {
        logic              valid;
        logic [PREG_W-1:0] prd;
    } iq_wb_t;

    typedef struct packed {
        logic    valid;
        rob_id_t robid;
    } iq_flush_t;

endpackage

`default_nettype wire

/* hdl/iq_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_entry (
    input  wire                                              clock,
    input  wire                                              reset_n,
    input  wire                                              enq_wren,
    input  wire int_isq_pkg::iq_enq_t                        enq_data,
    input  wire int_isq_pkg::iq_wb_t [int_isq_pkg::WB_PORTS-1:0] wb,
    input  wire int_isq_pkg::iq_flush_t                      flush,
    input  wire                                              issuing,
    output logic                                             valid,
    output logic                                             ready_to_go,
    output int_isq_pkg::iq_issue_t                           entry
);

    int_isq_pkg::iq_payload_t payload;
    int_isq_pkg::iq_src_t     src1;
    int_isq_pkg::iq_src_t     src2;
    logic                     src1_ready;
    logic                     src2_ready;
    logic                     src1_wake;
    logic                     src2_wake;
    logic                     flush_hit;

    // ------------------------------
    // Wakeup match
    // ------------------------------

    // Compare every writeback port against both waiting source registers
    always_comb begin
        src1_wake = 1'b0;
        src2_wake = 1'b0;
        for (int p = 0; p < int_isq_pkg::WB_PORTS; p++) begin
            if (wb[p].valid && src1.is_reg && (wb[p].prd == src1.preg)) begin
                src1_wake = 1'b1;
            end
            if (wb[p].valid && src2.is_reg && (wb[p].prd == src2.preg)) begin
                src2_wake = 1'b1;
            end
        end
    end

    // ------------------------------
    // Flush age compare
    // ------------------------------

    // Differing wrap bits invert the sense of the index comparison
    assign flush_hit = flush.valid && valid &&
        ((flush.robid[int_isq_pkg::ROB_IDX_W] ^ payload.robid[int_isq_pkg::ROB_IDX_W]) ^
         (flush.robid[int_isq_pkg::ROB_IDX_W-1:0] < payload.robid[int_isq_pkg::ROB_IDX_W-1:0]));

    // ------------------------------
    // State
    // ------------------------------

    always_ff @(posedge clock) begin
        if (enq_wren) begin
            payload <= enq_data.payload;
            src1    <= enq_data.src1;
            src2    <= enq_data.src2;
        end
    end

    // A write only lands in a free entry, so it never races with issue or flush here
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid      <= 1'b0;
            src1_ready <= 1'b0;
            src2_ready <= 1'b0;
        end else if (enq_wren) begin
            valid      <= 1'b1;
            src1_ready <= enq_data.src1_ready;
            src2_ready <= enq_data.src2_ready;
        end else begin
            if (issuing || flush_hit) begin
                valid <= 1'b0;
            end
            if (src1_wake) begin
                src1_ready <= 1'b1;
            end
            if (src2_wake) begin
                src2_ready <= 1'b1;
            end
        end
    end

    // An immediate or zero source never waits
    assign ready_to_go = valid &&
                         (src1_ready || !src1.is_reg) &&
                         (src2_ready || !src2.is_reg);

    assign entry = '{payload: payload, src1: src1, src2: src2};

endmodule

`default_nettype wire

/* hdl/isq_pmu.sv */
`timescale 1ns/1ps
`default_nettype none

module isq_pmu (
    input  wire                                        clock,
    input  wire                                        reset_n,
    input  wire                                        enq_valid,
    input  wire                                        can_alloc,
    input  wire                                        issue_valid,
    input  wire  [int_isq_pkg::ISSUE_QUEUE_DEPTH-1:0]  ready_vec,
    output logic [int_isq_pkg::PMU_CNT_W-1:0]          block_enq_cycles,
    output logic [int_isq_pkg::PMU_CNT_W-1:0]          can_issue_more
);

    logic [$clog2(int_isq_pkg::ISSUE_QUEUE_DEPTH+1)-1:0] ready_cnt;

    // Population count of entries that could issue this cycle
    always_comb begin
        ready_cnt = '0;
        for (int i = 0; i < int_isq_pkg::ISSUE_QUEUE_DEPTH; i++) begin
            if (ready_vec[i]) begin
                ready_cnt = ready_cnt + 1'b1;
            end
        end
    end

    // Dispatch asked but the queue was full
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            block_enq_cycles <= '0;
        end else if (enq_valid && !can_alloc) begin
            block_enq_cycles <= block_enq_cycles + 1'b1;
        end
    end

    // One issue port left other ready work waiting
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            can_issue_more <= '0;
        end else if (issue_valid && (ready_cnt > 1)) begin
            can_issue_more <= can_issue_more + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* int_isq.f */
hdl/int_isq_pkg.sv
hdl/iq_entry.sv
hdl/age_select.sv
hdl/isq_pmu.sv
hdl/int_isq.sv
bench/int_isq_checker.sv
bench/int_isq_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f int_isq.f \
    --top-module int_isq_tb \
    -o int_isq_sim

sim_output=$(./obj_dir/int_isq_sim)
echo "$sim_output"

if grep -qx "Regression passed" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi
